// File: Bender.yml
package:
  name: sccb_master

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sccb_bus_pkg.sv
      - rtl/sccb_ctrl_pkg.sv
      - rtl/sccb_req_decode.sv
      - rtl/sccb_sequencer.sv
      - rtl/i2c_bit_phy.sv
      - rtl/sccb_resp.sv
      - rtl/sccb_master_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/sccb_chk.sv
      - tests/sccb_monitor.sv
      - tests/sccb_tb.sv

// File: project.f
+incdir+rtl
rtl/sccb_bus_pkg.sv
rtl/sccb_ctrl_pkg.sv
rtl/sccb_req_decode.sv
rtl/sccb_sequencer.sv
rtl/i2c_bit_phy.sv
rtl/sccb_resp.sv
rtl/sccb_master_top.sv
tests/sccb_chk.sv
tests/sccb_monitor.sv
tests/sccb_tb.sv

// File: rtl/i2c_bit_phy.sv
// Fixed SCL timing with no clock stretching, no arbitration and SCCB_QUARTER of at least 2
`timescale 1ns/100ps
`include "sccb_defs.svh"

module i2c_bit_phy (
  input                            clk_i,
  input                            rst_i,
  input  sccb_ctrl_pkg::phy_cmd_e  cmd_i,
  input                            data_i,
  output logic                     data_o,
  output logic                     cmd_done_o,
  input                            sda_i,
  output logic                     sda_o,
  output logic                     sda_oe_o,
  input                            scl_i,
  output logic                     scl_o,
  output logic                     scl_oe_o
);

sccb_ctrl_pkg::phy_cmd_e cmd_q;
logic                    busy;
logic [$clog2(`SCCB_QUARTER)-1:0] q_cnt;
logic [1:0]              phase;
logic                    quarter_end;
logic                    sda_pull;
logic                    scl_pull;

// Pads only pull low and the external pull-up makes the high level
assign sda_o = 1'b0;
assign scl_o = 1'b0;

assign quarter_end = q_cnt == $bits( q_cnt )'( `SCCB_QUARTER - 1 );
assign cmd_done_o  = busy && quarter_end && phase == 2'd3;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      busy  <= 1'b0;
      cmd_q <= sccb_ctrl_pkg::CMD_NOP;
      q_cnt <= '0;
      phase <= 2'd0;
    end
  else
    if( !busy )
      begin
        if( cmd_i != sccb_ctrl_pkg::CMD_NOP )
          begin
            busy  <= 1'b1;
            cmd_q <= cmd_i;
            q_cnt <= '0;
            phase <= 2'd0;
          end
      end
    else
      if( quarter_end )
        begin
          q_cnt <= '0;
          phase <= phase + 2'd1;
          if( phase == 2'd3 )
            busy <= 1'b0;
        end
      else
        q_cnt <= q_cnt + 1'b1;

// Line shape per quarter where 1 means pulled low
always_comb
  begin
    sda_pull = sda_oe_o;
    scl_pull = phase == 2'd0 || phase == 2'd3;
    case( cmd_q )
      // SDA released, SCL released, SDA falls, SCL falls
      sccb_ctrl_pkg::CMD_START:
        begin
          sda_pull = phase[1];
          scl_pull = phase == 2'd0 || phase == 2'd3;
        end
      // SDA low, SCL released, SDA rises
      sccb_ctrl_pkg::CMD_STOP:
        begin
          sda_pull = !phase[1];
          scl_pull = phase == 2'd0;
        end
      sccb_ctrl_pkg::CMD_WRITE: sda_pull = !data_i;
      sccb_ctrl_pkg::CMD_READ:  sda_pull = 1'b0;
      default:
        begin
          sda_pull = sda_oe_o;
          scl_pull = scl_oe_o;
        end
    endcase
  end

// Outputs hold their last level between commands
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      sda_oe_o <= 1'b0;
      scl_oe_o <= 1'b0;
    end
  else
    if( busy )
      begin
        sda_oe_o <= sda_pull;
        scl_oe_o <= scl_pull;
      end

// Sample at the start of the third quarter and read a low SCL as a high bit
always_ff @( posedge clk_i )
  if( busy && cmd_q == sccb_ctrl_pkg::CMD_READ && phase == 2'd2 && q_cnt == '0 )
    data_o <= sda_i || !scl_i;

endmodule

// File: rtl/sccb_bus_pkg.sv
// AXI4-Lite bundles carry only the fields this master uses and have no strobe or protection bits
`include "sccb_defs.svh"

package sccb_bus_pkg;

// Response codes on the B and R channels
typedef enum logic [1:0] {
  RESP_OKAY   = 2'b00,
  RESP_SLVERR = 2'b10
} axil_resp_e;

// Master to slave
typedef struct packed {
  logic                    awvalid;
  logic [`SCCB_SUB_W-1:0]  awaddr;
  logic                    wvalid;
  logic [`SCCB_DATA_W-1:0] wdata;
  logic                    arvalid;
  logic [`SCCB_SUB_W-1:0]  araddr;
  logic                    bready;
  logic                    rready;
} axil_req_t;

// Slave to master
typedef struct packed {
  logic                    awready;
  logic                    wready;
  logic                    arready;
  logic                    bvalid;
  axil_resp_e              bresp;
  logic                    rvalid;
  logic [`SCCB_DATA_W-1:0] rdata;
  axil_resp_e              rresp;
} axil_rsp_t;

endpackage

// File: rtl/sccb_ctrl_pkg.sv
// Internal control types of the SCCB master and only one request is in flight at a time
`include "sccb_defs.svh"

package sccb_ctrl_pkg;

// Bit level commands for the PHY
typedef enum logic [2:0] {
  CMD_NOP   = 3'd0,
  CMD_START = 3'd1,
  CMD_STOP  = 3'd2,
  CMD_WRITE = 3'd3,
  CMD_READ  = 3'd4
} phy_cmd_e;

// Frame sequence, shared by reads and writes up to the register address
typedef enum logic [3:0] {
  IDLE_S,
  START_0_S,
  SLAVE_ADDR_0_S,
  ACK_0_S,
  SUB_ADDR_MSB_S,
  ACK_1_S,
  SUB_ADDR_LSB_S,
  ACK_2_S,
  START_1_S,
  SLAVE_ADDR_1_S,
  ACK_3_S,
  WR_DATA_S,
  RD_DATA_S,
  NACK_S,
  STOP_S
} seq_state_e;

typedef struct packed {
  logic                    rd;
  logic [`SCCB_SUB_W-1:0]  sub_addr;
  logic [`SCCB_DATA_W-1:0] wdata;
} sccb_req_t;

typedef struct packed {
  logic                    rd;
  logic                    nack;
  logic [`SCCB_DATA_W-1:0] rdata;
} sccb_result_t;

endpackage

// File: rtl/sccb_defs.svh
// Timing and width constants for the SCCB master and its testbench where SCCB_QUARTER must be 2 or more
`ifndef SCCB_DEFS_SVH
`define SCCB_DEFS_SVH

// clk_i cycles per quarter of an SCL period
`define SCCB_QUARTER 10

// Sensor register address width, taken from the low AXI address bits
`define SCCB_SUB_W 16

// Sensor register data width, taken from the low AXI data bits
`define SCCB_DATA_W 8

`endif

// File: rtl/sccb_master_top.sv
// SCCB master with an AXI4-Lite slave port and open-drain pads that need an external pull-up
`timescale 1ns/100ps
`include "sccb_defs.svh"

module sccb_master_top (
  input                             clk_i,
  input                             rst_i,
  input  sccb_bus_pkg::axil_req_t   axil_req_i,
  output sccb_bus_pkg::axil_rsp_t   axil_rsp_o,
  input        [6:0]                slave_addr_i,
  input                             sda_i,
  output logic                      sda_o,
  output logic                      sda_oe_o,
  input                             scl_i,
  output logic                      scl_o,
  output logic                      scl_oe_o
);

sccb_ctrl_pkg::sccb_req_t    req;
sccb_ctrl_pkg::sccb_result_t result;
sccb_ctrl_pkg::phy_cmd_e     phy_cmd;
sccb_bus_pkg::axil_resp_e    bresp;
sccb_bus_pkg::axil_resp_e    rresp;
logic [`SCCB_DATA_W-1:0]     rdata;
logic                        awready;
logic                        wready;
logic                        arready;
logic                        bvalid;
logic                        rvalid;
logic                        req_stb;
logic                        result_stb;
logic                        txn_done;
logic                        phy_tx_bit;
logic                        phy_rx_bit;
logic                        phy_done;

assign axil_rsp_o.awready = awready;
assign axil_rsp_o.wready  = wready;
assign axil_rsp_o.arready = arready;
assign axil_rsp_o.bvalid  = bvalid;
assign axil_rsp_o.bresp   = bresp;
assign axil_rsp_o.rvalid  = rvalid;
assign axil_rsp_o.rdata   = rdata;
assign axil_rsp_o.rresp   = rresp;

sccb_req_decode i_sccb_req_decode (
  .clk_i      ( clk_i      ),
  .rst_i      ( rst_i      ),
  .axil_req_i ( axil_req_i ),
  .txn_done_i ( txn_done   ),
  .awready_o  ( awready    ),
  .wready_o   ( wready     ),
  .arready_o  ( arready    ),
  .req_stb_o  ( req_stb    ),
  .req_o      ( req        )
);

sccb_sequencer i_sccb_sequencer (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .req_stb_i    ( req_stb      ),
  .req_i        ( req          ),
  .slave_addr_i ( slave_addr_i ),
  .phy_done_i   ( phy_done     ),
  .phy_rx_bit_i ( phy_rx_bit   ),
  .phy_cmd_o    ( phy_cmd      ),
  .phy_tx_bit_o ( phy_tx_bit   ),
  .result_stb_o ( result_stb   ),
  .result_o     ( result       )
);

i2c_bit_phy i_i2c_bit_phy (
  .clk_i      ( clk_i      ),
  .rst_i      ( rst_i      ),
  .cmd_i      ( phy_cmd    ),
  .data_i     ( phy_tx_bit ),
  .data_o     ( phy_rx_bit ),
  .cmd_done_o ( phy_done   ),
  .sda_i      ( sda_i      ),
  .sda_o      ( sda_o      ),
  .sda_oe_o   ( sda_oe_o   ),
  .scl_i      ( scl_i      ),
  .scl_o      ( scl_o      ),
  .scl_oe_o   ( scl_oe_o   )
);

sccb_resp i_sccb_resp (
  .clk_i        ( clk_i             ),
  .rst_i        ( rst_i             ),
  .result_stb_i ( result_stb        ),
  .result_i     ( result            ),
  .bready_i     ( axil_req_i.bready ),
  .rready_i     ( axil_req_i.rready ),
  .bvalid_o     ( bvalid            ),
  .bresp_o      ( bresp             ),
  .rvalid_o     ( rvalid            ),
  .rdata_o      ( rdata             ),
  .rresp_o      ( rresp             ),
  .txn_done_o   ( txn_done          )
);

endmodule

// File: rtl/sccb_req_decode.sv
// Write needs awvalid and wvalid together and wins over a read offered in the same cycle
`timescale 1ns/100ps

module sccb_req_decode (
  input                             clk_i,
  input                             rst_i,
  input  sccb_bus_pkg::axil_req_t   axil_req_i,
  input                             txn_done_i,
  output logic                      awready_o,
  output logic                      wready_o,
  output logic                      arready_o,
  output logic                      req_stb_o,
  output sccb_ctrl_pkg::sccb_req_t  req_o
);

// Set from acceptance until the response handshake
logic slot_full;
logic wr_req;
logic rd_req;

assign wr_req = axil_req_i.awvalid && axil_req_i.wvalid;
assign rd_req = axil_req_i.arvalid && !wr_req;

assign awready_o = !slot_full;
assign wready_o  = !slot_full;
// A read losing to a write must not see its handshake complete
assign arready_o = !slot_full && !wr_req;

assign req_stb_o = !slot_full && ( wr_req || rd_req );

always_comb
  begin
    req_o.rd       = !wr_req;
    req_o.sub_addr = wr_req ? axil_req_i.awaddr : axil_req_i.araddr;
    req_o.wdata    = axil_req_i.wdata;
  end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    slot_full <= 1'b0;
  else
    if( req_stb_o )
      slot_full <= 1'b1;
    else
      if( txn_done_i )
        slot_full <= 1'b0;

endmodule

// File: rtl/sccb_resp.sv
// Holds one B or R response until the master takes it and a NACK result gives SLVERR
`timescale 1ns/100ps
`include "sccb_defs.svh"

module sccb_resp (
  input                                clk_i,
  input                                rst_i,
  input                                result_stb_i,
  input  sccb_ctrl_pkg::sccb_result_t  result_i,
  input                                bready_i,
  input                                rready_i,
  output logic                         bvalid_o,
  output sccb_bus_pkg::axil_resp_e     bresp_o,
  output logic                         rvalid_o,
  output logic [`SCCB_DATA_W-1:0]      rdata_o,
  output sccb_bus_pkg::axil_resp_e     rresp_o,
  output logic                         txn_done_o
);

sccb_bus_pkg::axil_resp_e resp_code;

assign resp_code  = result_i.nack ? sccb_bus_pkg::RESP_SLVERR : sccb_bus_pkg::RESP_OKAY;
assign txn_done_o = ( bvalid_o && bready_i ) || ( rvalid_o && rready_i );

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end
  else
    if( result_stb_i )
      begin
        bvalid_o <= !result_i.rd;
        rvalid_o <= result_i.rd;
      end
    else
      begin
        if( bready_i )
          bvalid_o <= 1'b0;
        if( rready_i )
          rvalid_o <= 1'b0;
      end

always_ff @( posedge clk_i )
  if( result_stb_i )
    begin
      bresp_o <= resp_code;
      rresp_o <= resp_code;
      rdata_o <= result_i.rdata;
    end

endmodule

// File: rtl/sccb_sequencer.sv
// One register access per request and a missing ACK jumps to STOP and reports nack with zero data
`timescale 1ns/100ps
`include "sccb_defs.svh"

module sccb_sequencer (
  input                                clk_i,
  input                                rst_i,
  input                                req_stb_i,
  input  sccb_ctrl_pkg::sccb_req_t     req_i,
  input        [6:0]                   slave_addr_i,
  input                                phy_done_i,
  input                                phy_rx_bit_i,
  output sccb_ctrl_pkg::phy_cmd_e      phy_cmd_o,
  output logic                         phy_tx_bit_o,
  output logic                         result_stb_o,
  output sccb_ctrl_pkg::sccb_result_t  result_o
);

sccb_ctrl_pkg::seq_state_e state;
sccb_ctrl_pkg::seq_state_e next_state;
sccb_ctrl_pkg::sccb_req_t  req_q;

// Outgoing byte, MSB first
logic [`SCCB_DATA_W-1:0] tx_shift;
logic [`SCCB_DATA_W-1:0] rx_shift;
logic [2:0]              bit_cnt;
logic                    nack;
logic                    byte_state;
logic                    ack_state;
logic                    byte_last;
logic                    stop_done;

assign byte_state = state inside { sccb_ctrl_pkg::SLAVE_ADDR_0_S, sccb_ctrl_pkg::SUB_ADDR_MSB_S,
                                   sccb_ctrl_pkg::SUB_ADDR_LSB_S, sccb_ctrl_pkg::SLAVE_ADDR_1_S,
                                   sccb_ctrl_pkg::WR_DATA_S,      sccb_ctrl_pkg::RD_DATA_S };
assign ack_state  = state inside { sccb_ctrl_pkg::ACK_0_S, sccb_ctrl_pkg::ACK_1_S,
                                   sccb_ctrl_pkg::ACK_2_S, sccb_ctrl_pkg::ACK_3_S };
assign byte_last  = phy_done_i && bit_cnt == 3'd7;
assign stop_done  = phy_done_i && state == sccb_ctrl_pkg::STOP_S;

assign phy_tx_bit_o = tx_shift[`SCCB_DATA_W-1];

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    state <= sccb_ctrl_pkg::IDLE_S;
  else
    state <= next_state;

always_comb
  begin
    next_state = state;
    case( state )
      sccb_ctrl_pkg::IDLE_S:
        if( req_stb_i )
          next_state = sccb_ctrl_pkg::START_0_S;
      sccb_ctrl_pkg::START_0_S:
        if( phy_done_i )
          next_state = sccb_ctrl_pkg::SLAVE_ADDR_0_S;
      sccb_ctrl_pkg::SLAVE_ADDR_0_S:
        if( byte_last )
          next_state = sccb_ctrl_pkg::ACK_0_S;
      sccb_ctrl_pkg::ACK_0_S:
        if( phy_done_i )
          next_state = phy_rx_bit_i ? sccb_ctrl_pkg::STOP_S : sccb_ctrl_pkg::SUB_ADDR_MSB_S;
      sccb_ctrl_pkg::SUB_ADDR_MSB_S:
        if( byte_last )
          next_state = sccb_ctrl_pkg::ACK_1_S;
      sccb_ctrl_pkg::ACK_1_S:
        if( phy_done_i )
          next_state = phy_rx_bit_i ? sccb_ctrl_pkg::STOP_S : sccb_ctrl_pkg::SUB_ADDR_LSB_S;
      sccb_ctrl_pkg::SUB_ADDR_LSB_S:
        if( byte_last )
          next_state = sccb_ctrl_pkg::ACK_2_S;
      sccb_ctrl_pkg::ACK_2_S:
        if( phy_done_i )
          if( phy_rx_bit_i )
            next_state = sccb_ctrl_pkg::STOP_S;
          else
            next_state = req_q.rd ? sccb_ctrl_pkg::START_1_S : sccb_ctrl_pkg::WR_DATA_S;
      sccb_ctrl_pkg::START_1_S:
        if( phy_done_i )
          next_state = sccb_ctrl_pkg::SLAVE_ADDR_1_S;
      sccb_ctrl_pkg::SLAVE_ADDR_1_S:
        if( byte_last )
          next_state = sccb_ctrl_pkg::ACK_3_S;
      sccb_ctrl_pkg::ACK_3_S:
        if( phy_done_i )
          next_state = phy_rx_bit_i ? sccb_ctrl_pkg::STOP_S : sccb_ctrl_pkg::RD_DATA_S;
      sccb_ctrl_pkg::WR_DATA_S,
      sccb_ctrl_pkg::RD_DATA_S:
        if( byte_last )
          next_state = sccb_ctrl_pkg::NACK_S;
      sccb_ctrl_pkg::NACK_S:
        if( phy_done_i )
          next_state = sccb_ctrl_pkg::STOP_S;
      sccb_ctrl_pkg::STOP_S:
        if( phy_done_i )
          next_state = sccb_ctrl_pkg::IDLE_S;
      default:
        next_state = sccb_ctrl_pkg::IDLE_S;
    endcase
  end

always_ff @( posedge clk_i )
  if( state == sccb_ctrl_pkg::IDLE_S && req_stb_i )
    req_q <= req_i;

// Load a byte on entry to its state, shift once per finished bit
always_ff @( posedge clk_i )
  if( state != next_state )
    case( next_state )
      sccb_ctrl_pkg::SLAVE_ADDR_0_S: tx_shift <= { slave_addr_i, 1'b0 };
      sccb_ctrl_pkg::SUB_ADDR_MSB_S: tx_shift <= req_q.sub_addr[`SCCB_SUB_W-1 -: `SCCB_DATA_W];
      sccb_ctrl_pkg::SUB_ADDR_LSB_S: tx_shift <= req_q.sub_addr[`SCCB_DATA_W-1:0];
      sccb_ctrl_pkg::SLAVE_ADDR_1_S: tx_shift <= { slave_addr_i, 1'b1 };
      sccb_ctrl_pkg::WR_DATA_S:      tx_shift <= req_q.wdata;
      // Released SDA in the ninth bit of a read is the master NACK
      sccb_ctrl_pkg::NACK_S:         tx_shift <= { 1'b1, { ( `SCCB_DATA_W - 1 ){ 1'b0 } } };
      default:                       tx_shift <= tx_shift;
    endcase
  else
    if( byte_state && phy_done_i )
      tx_shift <= tx_shift << 1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    bit_cnt <= 3'd0;
  else
    if( byte_state && phy_done_i )
      bit_cnt <= bit_cnt + 3'd1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      rx_shift <= '0;
      nack     <= 1'b0;
    end
  else
    if( state == sccb_ctrl_pkg::IDLE_S && req_stb_i )
      begin
        rx_shift <= '0;
        nack     <= 1'b0;
      end
    else
      if( phy_done_i )
        if( state == sccb_ctrl_pkg::RD_DATA_S )
          rx_shift <= { rx_shift[`SCCB_DATA_W-2:0], phy_rx_bit_i };
        else
          // Ninth bit of a write checks the sensor ACK of the data byte
          if( phy_rx_bit_i && ( ack_state || ( state == sccb_ctrl_pkg::NACK_S && !req_q.rd ) ) )
            begin
              nack     <= 1'b1;
              rx_shift <= '0;
            end

// Command follows the state entered, so it holds until phy_done_i
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    phy_cmd_o <= sccb_ctrl_pkg::CMD_NOP;
  else
    case( next_state )
      sccb_ctrl_pkg::START_0_S,
      sccb_ctrl_pkg::START_1_S:      phy_cmd_o <= sccb_ctrl_pkg::CMD_START;
      sccb_ctrl_pkg::SLAVE_ADDR_0_S,
      sccb_ctrl_pkg::SUB_ADDR_MSB_S,
      sccb_ctrl_pkg::SUB_ADDR_LSB_S,
      sccb_ctrl_pkg::SLAVE_ADDR_1_S,
      sccb_ctrl_pkg::WR_DATA_S:      phy_cmd_o <= sccb_ctrl_pkg::CMD_WRITE;
      sccb_ctrl_pkg::ACK_0_S,
      sccb_ctrl_pkg::ACK_1_S,
      sccb_ctrl_pkg::ACK_2_S,
      sccb_ctrl_pkg::ACK_3_S,
      sccb_ctrl_pkg::RD_DATA_S:      phy_cmd_o <= sccb_ctrl_pkg::CMD_READ;
      sccb_ctrl_pkg::NACK_S:
        phy_cmd_o <= req_q.rd ? sccb_ctrl_pkg::CMD_WRITE : sccb_ctrl_pkg::CMD_READ;
      sccb_ctrl_pkg::STOP_S:         phy_cmd_o <= sccb_ctrl_pkg::CMD_STOP;
      default:                       phy_cmd_o <= sccb_ctrl_pkg::CMD_NOP;
    endcase

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    result_stb_o <= 1'b0;
  else
    result_stb_o <= stop_done;

always_ff @( posedge clk_i )
  if( stop_done )
    begin
      result_o.rd    <= req_q.rd;
      result_o.nack  <= nack;
      result_o.rdata <= rx_shift;
    end

endmodule

// File: tests/sccb_chk.sv
// Bound into sccb_master_top and only checks while rst_i is low
`timescale 1ns/100ps

module sccb_chk (
  input                           clk_i,
  input                           rst_i,
  input  sccb_bus_pkg::axil_req_t req_i,
  input  sccb_bus_pkg::axil_rsp_t rsp_i,
  input  sccb_ctrl_pkg::phy_cmd_e phy_cmd_i,
  input                           phy_done_i
);

b_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid && $stable( rsp_i.bresp ) )
  else $error( "bvalid dropped or bresp changed before bready" );

r_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid && $stable( rsp_i.rdata ) &&
  $stable( rsp_i.rresp ) )
  else $error( "rvalid dropped or read data changed before rready" );

aw_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  req_i.awvalid && !rsp_i.awready |=> req_i.awvalid && $stable( req_i.awaddr ) )
  else $error( "awvalid dropped or awaddr changed before awready" );

ar_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  req_i.arvalid && !rsp_i.arready |=> req_i.arvalid && $stable( req_i.araddr ) )
  else $error( "arvalid dropped or araddr changed before arready" );

// A bit command runs to its end
cmd_hold: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  phy_cmd_i != sccb_ctrl_pkg::CMD_NOP && !phy_done_i |=> $stable( phy_cmd_i ) )
  else $error( "PHY command changed before phy_done" );

ready_low: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  rsp_i.bvalid || rsp_i.rvalid |-> !rsp_i.awready && !rsp_i.wready && !rsp_i.arready )
  else $error( "request ready high while a response is pending" );

endmodule

// File: tests/sccb_monitor.sv
// Expected responses must be queued in the order the requests are accepted
`timescale 1ns/100ps

module sccb_monitor (
  input                           clk_i,
  input                           rst_i,
  input  sccb_bus_pkg::axil_req_t req_i,
  input  sccb_bus_pkg::axil_rsp_t rsp_i
);

typedef struct packed {
  logic       rd;
  logic [1:0] resp;
  logic [7:0] rdata;
} exp_entry_t;

exp_entry_t exp_q[$];
int         error_count = 0;
int         check_count = 0;

task automatic push_expect(input logic rd, input logic [1:0] resp, input logic [7:0] rdata);
  exp_entry_t entry;
  begin
    entry.rd    = rd;
    entry.resp  = resp;
    entry.rdata = rdata;
    exp_q.push_back(entry);
  end
endtask

function automatic int pending_count();
  return exp_q.size();
endfunction

task automatic compare_response(input logic rd, input logic [1:0] resp, input logic [7:0] rdata);
  exp_entry_t entry;
  begin
    if (exp_q.size() == 0)
    begin
      $display("Response on the %s channel at %0t with no transaction outstanding",
               rd ? "R" : "B", $time);
      error_count++;
    end
    else
    begin
      entry = exp_q.pop_front();
      check_count++;
      if (entry.rd !== rd)
      begin
        $display("MISMATCH at %0t: response channel got %s expected %s", $time,
                 rd ? "R" : "B", entry.rd ? "R" : "B");
        error_count++;
      end
      else if (entry.resp !== resp)
      begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time,
                 rd ? "rresp" : "bresp", resp, entry.resp);
        error_count++;
      end
      // Data only matters on reads
      if (entry.rd === rd && rd && entry.rdata !== rdata)
      begin
        $display("MISMATCH at %0t: rdata got %h expected %h", $time, rdata, entry.rdata);
        error_count++;
      end
    end
  end
endtask

always @(posedge clk_i)
  if (!rst_i)
  begin
    if (rsp_i.bvalid && req_i.bready)
      compare_response(1'b0, rsp_i.bresp, 8'h00);
    if (rsp_i.rvalid && req_i.rready)
      compare_response(1'b1, rsp_i.rresp, rsp_i.rdata);
  end

endmodule

// File: tests/sccb_stimulus.txt
# op dev reg data resp rdata, all hex
# op W write, R read, P write and read offered together; resp 0 OKAY, 2 SLVERR
W 3C 1234 A5 0 00
R 3C 1234 00 0 A5
R 3C 0055 00 0 00
W 3C 0010 5A 0 00
W 3C 0011 C3 0 00
R 3C 0010 00 0 5A
W 21 1234 FF 2 00
R 21 1234 00 2 00
R 3C 0011 00 0 C3
P 3C 0077 96 0 96
R 3C 1234 00 0 A5
R 3C 0077 00 0 96
W 3C 1134 3E 0 00
R 3C 1234 00 0 3E

// File: tests/sccb_tb.sv
// Sensor model answers only at 7'h3C and indexes its registers by the low address byte
`timescale 1ns/100ps
`include "sccb_defs.svh"

module sccb_tb;

localparam int MAX_LINES = 64;
localparam int PH_RX = 0;
localparam int PH_ACK = 1;
localparam int PH_TX = 2;
localparam int PH_MACK = 3;

logic clk_i;
logic rst_i;
sccb_bus_pkg::axil_req_t req;
sccb_bus_pkg::axil_rsp_t rsp;
logic [6:0] slave_addr;
logic sda;
logic scl;
logic dut_sda_o;
logic dut_sda_oe;
logic dut_scl_o;
logic dut_scl_oe;
integer seed = 81030;
int tb_errors = 0;

// Stimulus table
logic [7:0]  st_op [MAX_LINES];
logic [6:0]  st_dev [MAX_LINES];
logic [15:0] st_addr [MAX_LINES];
logic [7:0]  st_data [MAX_LINES];
logic [1:0]  st_resp [MAX_LINES];
logic [7:0]  st_rdata [MAX_LINES];
int n_lines = 0;
int n_txn = 0;

// Sensor model state
logic [7:0]  sensor_regs [256];
logic        sensor_pull;
logic        sensor_active;
int          sensor_phase;
int          sensor_bits;
int          sensor_byte;
logic        sensor_rd;
logic [7:0]  sensor_shift;
logic [15:0] sensor_sub;

// Wired-AND bus with pull-up
assign sda = ( dut_sda_oe ? dut_sda_o : 1'b1 ) && !sensor_pull;
assign scl = dut_scl_oe ? dut_scl_o : 1'b1;

sccb_master_top i_sccb_master_top (
  .clk_i        ( clk_i      ),
  .rst_i        ( rst_i      ),
  .axil_req_i   ( req        ),
  .axil_rsp_o   ( rsp        ),
  .slave_addr_i ( slave_addr ),
  .sda_i        ( sda        ),
  .sda_o        ( dut_sda_o  ),
  .sda_oe_o     ( dut_sda_oe ),
  .scl_i        ( scl        ),
  .scl_o        ( dut_scl_o  ),
  .scl_oe_o     ( dut_scl_oe )
);

sccb_monitor i_sccb_monitor (
  .clk_i ( clk_i ),
  .rst_i ( rst_i ),
  .req_i ( req   ),
  .rsp_i ( rsp   )
);

bind sccb_master_top sccb_chk i_sccb_chk (
  .clk_i      ( clk_i      ),
  .rst_i      ( rst_i      ),
  .req_i      ( axil_req_i ),
  .rsp_i      ( axil_rsp_o ),
  .phy_cmd_i  ( phy_cmd    ),
  .phy_done_i ( phy_done   )
);

initial
begin
  clk_i = 1'b0;
  forever #10 clk_i = !clk_i;
end

// Start and stop are SDA edges while SCL is high
always @(negedge sda)
  if (scl === 1'b1)
  begin
    sensor_active = 1'b1;
    sensor_phase  = PH_RX;
    sensor_bits   = 0;
    sensor_byte   = 0;
    sensor_pull   = 1'b0;
  end

always @(posedge sda)
  if (scl === 1'b1)
  begin
    sensor_active = 1'b0;
    sensor_pull   = 1'b0;
  end

always @(posedge scl)
  if (sensor_active && sensor_phase == PH_RX)
  begin
    sensor_shift = {sensor_shift[6:0], sda};
    sensor_bits++;
  end

task automatic take_byte();
  begin
    if (sensor_byte == 0 && sensor_shift[7:1] != 7'h3C)
      sensor_active = 1'b0;
    else
    begin
      case (sensor_byte)
        0: sensor_rd = sensor_shift[0];
        1: sensor_sub[15:8] = sensor_shift;
        2: sensor_sub[7:0] = sensor_shift;
        default: sensor_regs[sensor_sub[7:0]] = sensor_shift;
      endcase
      sensor_pull  = 1'b1;
      sensor_phase = PH_ACK;
      if (sensor_byte < 3)
        sensor_byte++;
    end
  end
endtask

// SDA changes only while SCL is low
always @(negedge scl)
  if (sensor_active)
    case (sensor_phase)
      PH_RX:
        if (sensor_bits == 8)
          take_byte();
      PH_ACK:
      begin
        sensor_pull = 1'b0;
        sensor_bits = 0;
        sensor_phase = PH_RX;
        if (sensor_rd)
        begin
          sensor_shift = sensor_regs[sensor_sub[7:0]];
          sensor_pull  = !sensor_shift[7];
          sensor_bits  = 1;
          sensor_phase = PH_TX;
        end
      end
      PH_TX:
        if (sensor_bits == 8)
        begin
          sensor_pull  = 1'b0;
          sensor_phase = PH_MACK;
        end
        else
        begin
          sensor_pull = !sensor_shift[7 - sensor_bits];
          sensor_bits++;
        end
      default:
      begin
        sensor_pull   = 1'b0;
        sensor_active = 1'b0;
      end
    endcase

// Sensor registers read as zero until written
task automatic clear_sensor();
  begin
    for (int i = 0; i < 256; i++)
      sensor_regs[i] = 8'h00;
    sensor_active = 1'b0;
    sensor_pull   = 1'b0;
    sensor_rd     = 1'b0;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
  if (got !== want)
  begin
    $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want);
    tb_errors++;
  end
endtask

task automatic load_stimulus();
  int fd;
  int n;
  string line;
  begin
    fd = $fopen("tests/sccb_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file tests/sccb_stimulus.txt");
      tb_errors++;
    end
    else
    begin
      while (!$feof(fd) && n_lines < MAX_LINES)
      begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 0 && line[0] != "#")
        begin
          n = $sscanf(line, "%c %h %h %h %h %h", st_op[n_lines], st_dev[n_lines],
                      st_addr[n_lines], st_data[n_lines], st_resp[n_lines], st_rdata[n_lines]);
          if (n == 6)
          begin
            n_txn += (st_op[n_lines] == "P") ? 2 : 1;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  end
endtask

// Device pin may change only while no transaction is in flight
task automatic select_device(input logic [6:0] dev);
  if (dev != slave_addr)
  begin
    while (!rsp.awready)
    begin
      @(posedge clk_i);
      #2;
    end
    slave_addr = dev;
  end
endtask

task automatic wait_write_accept();
  begin
    @(negedge clk_i);
    while (!(rsp.awready && rsp.wready))
      @(negedge clk_i);
    @(posedge clk_i);
    #2;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
  end
endtask

task automatic wait_read_accept();
  begin
    @(negedge clk_i);
    while (!rsp.arready)
      @(negedge clk_i);
    @(posedge clk_i);
    #2;
    req.arvalid = 1'b0;
  end
endtask

task automatic run_line(input int i);
  begin
    select_device(st_dev[i]);
    if (st_op[i] == "W" || st_op[i] == "P")
    begin
      req.awvalid = 1'b1;
      req.awaddr  = st_addr[i];
      req.wvalid  = 1'b1;
      req.wdata   = st_data[i];
      i_sccb_monitor.push_expect(1'b0, st_resp[i], 8'h00);
    end
    if (st_op[i] == "R" || st_op[i] == "P")
    begin
      req.arvalid = 1'b1;
      req.araddr  = st_addr[i];
      i_sccb_monitor.push_expect(1'b1, st_resp[i], st_rdata[i]);
    end
    if (st_op[i] == "W" || st_op[i] == "P")
      wait_write_accept();
    if (st_op[i] == "R" || st_op[i] == "P")
      wait_read_accept();
    if (st_op[i] != "W" && st_op[i] != "R" && st_op[i] != "P")
    begin
      $display("Unknown operation in stimulus line %0d", i);
      tb_errors++;
    end
  end
endtask

// Response side with random back-pressure
initial
begin
  int delay;
  @(negedge rst_i);
  forever
  begin
    @(negedge clk_i);
    if (rsp.bvalid || rsp.rvalid)
    begin
      delay = $unsigned($random(seed)) % 16;
      repeat (delay + 1) @(posedge clk_i);
      #2;
      req.bready = 1'b1;
      req.rready = 1'b1;
      @(posedge clk_i);
      #2;
      req.bready = 1'b0;
      req.rready = 1'b0;
    end
  end
end

initial
begin
  longint limit_ns;
  rst_i = 1'b1;
  req = '0;
  slave_addr = 7'h3C;
  clear_sensor();
  load_stimulus();
  limit_ns = longint'(n_txn) * 48 * (4 * `SCCB_QUARTER + 1) * 20 * 2;
  fork
    begin
      #(limit_ns);
      $display("Run timed out at %0t before all responses arrived", $time);
      $display("Errors found");
      $finish;
    end
  join_none
  repeat (5) @(posedge clk_i);
  #2;
  rst_i = 1'b0;
  @(negedge clk_i);
  check_bit("awready", rsp.awready, 1'b1);
  check_bit("wready", rsp.wready, 1'b1);
  check_bit("arready", rsp.arready, 1'b1);
  check_bit("bvalid", rsp.bvalid, 1'b0);
  check_bit("rvalid", rsp.rvalid, 1'b0);
  check_bit("sda", sda, 1'b1);
  check_bit("scl", scl, 1'b1);
  check_bit("sda_o", dut_sda_o, 1'b0);
  check_bit("scl_o", dut_scl_o, 1'b0);
  @(posedge clk_i);
  #2;
  for (int i = 0; i < n_lines; i++)
    run_line(i);
  while (i_sccb_monitor.pending_count() != 0)
    @(posedge clk_i);
  repeat (4) @(posedge clk_i);
  $display("Responses checked %0d, monitor errors %0d, testbench errors %0d",
           i_sccb_monitor.check_count, i_sccb_monitor.error_count, tb_errors);
  if (i_sccb_monitor.error_count == 0 && tb_errors == 0 && n_lines > 0)
    $display("No errors");
  else
    $display("Errors found");
  $finish;
end

endmodule
